// File: nebula_ii.f
rtl/nebula_pkg.sv
rtl/wb_request_stage.sv
rtl/wb_decoder.sv
rtl/gpio_control.sv
rtl/la_control.sv
rtl/wb_sram.sv
rtl/team_sample.sv
rtl/nebula_ii.sv
verification/nebula_ii_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module nebula_ii_tb -f nebula_ii.f -o nebula_ii_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/nebula_ii_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

// File: verification/nebula_ii_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the shell top; host bus tasks, slave
// model and a queued compare process
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nebula_ii_tb;

    logic                clk;
    logic                rst;
    logic                cyc;
    logic                stb;
    nebula_pkg::wb_req_t host;       // Host-driven request fields
    logic                ack;
    logic [31:0]         dat_r;
    logic [127:0]        la_in;
    logic [127:0]        la_oenb;
    logic [127:0]        la_out;
    logic [37:0]         io_in;
    logic [37:0]         io_out;
    logic [37:0]         io_oeb;

    // Model state of the slaves
    logic [31:0]         sram_m [256];
    logic [31:0]         out_m;
    logic [31:0]         oeb_m;
    logic [31:0]         sel_lo_m;
    logic [5:0]          sel_hi_m;
    logic [3:0]          la_sel_m;
    logic [31:0]         seed;

    // Pending checks, consumed by the compare process
    string               name_q [$];
    logic [127:0]        exp_q [$];
    logic [127:0]        act_q [$];
    int                  pass_cnt;
    int                  fail_cnt;
    int                  timeout_cnt;

    nebula_ii DUT (
        .wb_clk_i(clk), .rst_i(rst),
        .wbs_stb_i(stb), .wbs_cyc_i(cyc), .wbs_we_i(host.we), .wbs_sel_i(host.sel),
        .wbs_dat_i(host.dat), .wbs_adr_i(host.adr),
        .wbs_ack_o(ack), .wbs_dat_o(dat_r),
        .la_data_i(la_in), .la_oenb_i(la_oenb), .la_data_o(la_out),
        .io_i(io_in), .io_o(io_out), .io_oeb_o(io_oeb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // Stops a run that never reaches its end
    initial begin
        #200000;
        $display("Watchdog expired before the test sequence finished");
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] lane_merge(input logic [31:0] old_w, new_w,
                                               input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] slot_adr(input logic [3:0] slot, input logic [19:0] ofs);
        return {nebula_pkg::WB_BASE[31:24], slot, ofs};
    endfunction

    function automatic logic is_mapped(input logic [31:0] a);
        return (a[31:24] == nebula_pkg::WB_BASE[31:24]) && (a[23:20] <= nebula_pkg::SLOT_SRAM);
    endfunction

    // Reference read data from the model and the live pins
    function automatic logic [31:0] ref_read(input logic [31:0] a, input logic [37:0] pins);
        logic [31:0] r;
        r = nebula_pkg::ERR_DATA;                  // Unmapped default
        if (is_mapped(a)) begin
            case (a[23:20])
                nebula_pkg::SLOT_TEAM: begin
                    case (a[3:2])
                        2'd0:    r = out_m;
                        2'd1:    r = oeb_m;
                        2'd2:    r = pins[31:0];
                        default: r = 32'h0;
                    endcase
                end
                nebula_pkg::SLOT_LA:   r = {28'b0, la_sel_m};  // Any offset
                nebula_pkg::SLOT_GPIO: r = a[2] ? {26'b0, sel_hi_m} : sel_lo_m;
                default:               r = sram_m[a[9:2]];     // Upper bits alias
            endcase
        end
        return r;
    endfunction

    // Model update for a write
    function automatic void model_write(input logic [31:0] a, d, input logic [3:0] be);
        logic [31:0] tmp;
        if (is_mapped(a)) begin
            case (a[23:20])
                nebula_pkg::SLOT_TEAM: begin
                    if (a[3:2] == 2'd0)
                        out_m = lane_merge(out_m, d, be);
                    else if (a[3:2] == 2'd1)
                        oeb_m = lane_merge(oeb_m, d, be);
                end
                nebula_pkg::SLOT_LA: begin
                    tmp = lane_merge({28'b0, la_sel_m}, d, be);
                    la_sel_m = tmp[3:0];
                end
                nebula_pkg::SLOT_GPIO: begin
                    if (a[2]) begin
                        tmp = lane_merge({26'b0, sel_hi_m}, d, be);
                        sel_hi_m = tmp[5:0];
                    end else begin
                        sel_lo_m = lane_merge(sel_lo_m, d, be);
                    end
                end
                default: sram_m[a[9:2]] = lane_merge(sram_m[a[9:2]], d, be);
            endcase
        end
    endfunction

    // Expected pad outputs, pin by pin
    function automatic logic [37:0] exp_io();
        logic [37:0] sel;
        logic [37:0] team;
        logic [37:0] r;
        sel  = {sel_hi_m, sel_lo_m};
        team = 38'(out_m);                   // OUT zero-extended
        for (int p = 0; p < 38; p++)
            r[p] = sel[p] ? team[p] : 1'b0;  // Unselected pin drives zero
        return r;
    endfunction

    function automatic logic [37:0] exp_oeb();
        logic [37:0] sel;
        logic [37:0] team;
        logic [37:0] r;
        sel  = {sel_hi_m, sel_lo_m};
        team = {6'h3f, oeb_m};               // Top six pins never enabled by the team
        for (int p = 0; p < 38; p++)
            r[p] = sel[p] ? team[p] : 1'b1;  // Unselected pin stays disabled
        return r;
    endfunction

    function automatic logic [127:0] exp_la();
        logic [127:0] team_words;
        logic [127:0] r;
        team_words = {96'b0, out_m};
        r = '0;
        for (int w = 0; w < 4; w++) begin
            if (la_sel_m[w])
                r[32*w +: 32] = team_words[32*w +: 32];
        end
        return r;
    endfunction

    task automatic expect_eq(input string nm, input logic [127:0] e, a);
        name_q.push_back(nm);
        exp_q.push_back(e);
        act_q.push_back(a);
    endtask

    // Compare process runs mid-cycle
    always @(negedge clk) begin
        string        nm;
        logic [127:0] e;
        logic [127:0] a;
        while (name_q.size() != 0) begin
            nm = name_q.pop_front();
            e  = exp_q.pop_front();
            a  = act_q.pop_front();
            if (a !== e) begin
                $display("FAILED %s expected %0h actual %0h", nm, e, a);
                fail_cnt++;
            end else begin
                $display("passed %s", nm);
                pass_cnt++;
            end
        end
    end

    // One classic cycle with ack due 2 edges after the sampling edge
    task automatic bus_cycle(input logic wr, input logic [31:0] a, d, input logic [3:0] be,
                             output logic [31:0] rd);
        int   lat;
        logic seen;
        @(posedge clk);
        #2;
        host.adr = a;
        host.dat = d;
        host.sel = be;
        host.we  = wr;
        cyc = 1'b1;
        stb = 1'b1;
        @(posedge clk);                  // First edge that samples the request
        lat  = 0;
        seen = 1'b0;
        rd   = 32'h0;
        while (!seen && lat < 20) begin
            @(negedge clk);
            lat++;
            if (ack) begin
                seen = 1'b1;
                rd   = dat_r;
            end
        end
        if (!seen) begin
            $display("Timeout: no ack for address %08h within 20 cycles", a);
            timeout_cnt++;
        end else begin
            expect_eq($sformatf("ack latency %08h", a), 128'(2), 128'(lat));
        end
        @(posedge clk);                  // Host samples ack here
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        @(negedge clk);
        if (seen)
            expect_eq($sformatf("ack width %08h", a), 128'(1'b0), 128'(ack));
    endtask

    task automatic bus_write(input logic [31:0] a, d, input logic [3:0] be);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, a, d, be, unused_rd);
        model_write(a, d, be);
    endtask

    task automatic bus_read_check(input string nm, input logic [31:0] a);
        logic [31:0] rd;
        bus_cycle(1'b0, a, 32'h0, 4'hf, rd);
        expect_eq(nm, 128'(ref_read(a, io_in)), 128'(rd));
    endtask

    task automatic drive_pins(input logic [37:0] v);
        @(posedge clk);
        #2;
        io_in = v;
    endtask

    task automatic check_outputs(input string tag);
        expect_eq({tag, " io_o"}, 128'(exp_io()), 128'(io_out));
        expect_eq({tag, " io_oeb_o"}, 128'(exp_oeb()), 128'(io_oeb));
        expect_eq({tag, " la_data_o"}, exp_la(), la_out);
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  idx [8];
        int          tries;
        seed        = 32'h3c4a_2388;
        pass_cnt    = 0;
        fail_cnt    = 0;
        timeout_cnt = 0;
        rst     = 1'b1;
        cyc     = 1'b0;
        stb     = 1'b0;
        host    = '0;
        io_in   = '0;
        la_in   = '0;
        la_oenb = '0;
        out_m    = '0;
        oeb_m    = '0;
        sel_lo_m = '0;
        sel_hi_m = '0;
        la_sel_m = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        check_outputs("reset");
        expect_eq("reset ack", 128'(1'b0), 128'(ack));

        // SRAM full words first so every byte is defined
        for (int i = 0; i < 8; i++) begin
            r = lcg_next();
            idx[i] = r[7:0];
            bus_write(slot_adr(nebula_pkg::SLOT_SRAM, {10'h0, idx[i], 2'b00}), lcg_next(), 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            r = lcg_next();
            bus_write(slot_adr(nebula_pkg::SLOT_SRAM, {10'h0, idx[i], 2'b00}), lcg_next(), r[3:0]);
        end
        for (int i = 0; i < 8; i++)
            bus_read_check($sformatf("sram word %0d", idx[i]),
                           slot_adr(nebula_pkg::SLOT_SRAM, {10'h0, idx[i], 2'b00}));
        r = lcg_next();
        bus_read_check("sram alias",
                       slot_adr(nebula_pkg::SLOT_SRAM, {r[19:10] | 10'h1, idx[0], 2'b00}));

        // Team registers and pin routing
        bus_write(slot_adr(nebula_pkg::SLOT_TEAM, 20'h0), lcg_next(), 4'hf);
        bus_write(slot_adr(nebula_pkg::SLOT_TEAM, 20'h4), lcg_next(), 4'hf);
        bus_write(slot_adr(nebula_pkg::SLOT_GPIO, 20'h0), lcg_next(), 4'hf);
        bus_write(slot_adr(nebula_pkg::SLOT_GPIO, 20'h4), lcg_next(), 4'hf);
        check_outputs("gpio routing");
        r = lcg_next();
        bus_write(slot_adr(nebula_pkg::SLOT_TEAM, 20'h0), lcg_next(), r[3:0]);  // Partial lanes
        check_outputs("gpio after lane write");
        bus_read_check("gpio sel_lo", slot_adr(nebula_pkg::SLOT_GPIO, 20'h0));
        bus_read_check("gpio sel_hi", slot_adr(nebula_pkg::SLOT_GPIO, 20'h4));
        bus_read_check("team out", slot_adr(nebula_pkg::SLOT_TEAM, 20'h0));
        bus_read_check("team oeb", slot_adr(nebula_pkg::SLOT_TEAM, 20'h4));
        r = lcg_next();
        drive_pins({r[5:0], lcg_next()});
        bus_read_check("team in", slot_adr(nebula_pkg::SLOT_TEAM, 20'h8));

        // Analyzer word routing
        for (int i = 0; i < 4; i++) begin
            bus_write(slot_adr(nebula_pkg::SLOT_LA, 20'h0), lcg_next(), 4'hf);
            check_outputs($sformatf("la pass %0d", i));
            bus_read_check($sformatf("la sel %0d", i), slot_adr(nebula_pkg::SLOT_LA, 20'h0));
        end

        // Unmapped space answers with the error pattern
        bus_read_check("unmapped slot 5", slot_adr(4'd5, 20'h0));
        bus_read_check("outside base", 32'h4000_0000);
        bus_write(slot_adr(4'd5, 20'h0), 32'hffff_ffff, 4'hf);
        bus_write(32'h4020_0000, 32'hffff_ffff, 4'hf);   // GPIO slot bits under a wrong base
        check_outputs("after unmapped writes");

        tries = 0;
        while (name_q.size() != 0 && tries < 10) begin
            @(negedge clk);
            tries++;
        end
        if (name_q.size() != 0) begin
            $display("Compare process did not finish its pending checks");
            timeout_cnt++;
        end
        $display("Checks passed: %0d, failed: %0d, timeouts: %0d",
                 pass_cnt, fail_cnt, timeout_cnt);
        if (fail_cnt == 0 && timeout_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: rtl/nebula_ii.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// User-area shell top: host bus stage, decoder, team
// project, routing blocks and SRAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nebula_ii (
    input  logic         wb_clk_i,
    input  logic         rst_i,
    // Host Wishbone
    input  logic         wbs_stb_i,
    input  logic         wbs_cyc_i,
    input  logic         wbs_we_i,
    input  logic [3:0]   wbs_sel_i,
    input  logic [31:0]  wbs_dat_i,
    input  logic [31:0]  wbs_adr_i,
    output logic         wbs_ack_o,
    output logic [31:0]  wbs_dat_o,
    // Logic analyzer; inputs reserved for a team design
    input  logic [127:0] la_data_i,
    input  logic [127:0] la_oenb_i,
    output logic [127:0] la_data_o,
    // Chip pads
    input  logic [37:0]  io_i,
    output logic [37:0]  io_o,
    output logic [37:0]  io_oeb_o
);

    nebula_pkg::wb_req_t req;
    nebula_pkg::wb_rsp_t rsp;
    nebula_pkg::wb_rsp_t rsp_team, rsp_la, rsp_gpio, rsp_sram;
    logic                req_valid;
    logic                cyc_team, cyc_la, cyc_gpio, cyc_sram;
    logic [37:0]         team_gpio, team_oeb;
    logic [127:0]        team_la;

    wb_request_stage u_req (
        .wb_clk_i, .rst_i, .wbs_stb_i, .wbs_cyc_i, .wbs_we_i, .wbs_sel_i,
        .wbs_dat_i, .wbs_adr_i, .wbs_ack_o, .wbs_dat_o,
        .req_o(req), .req_valid_o(req_valid), .rsp_i(rsp)
    );

    wb_decoder u_dec (
        .wb_clk_i, .rst_i, .req_i(req), .req_valid_i(req_valid),
        .cyc_team_o(cyc_team), .cyc_la_o(cyc_la),
        .cyc_gpio_o(cyc_gpio), .cyc_sram_o(cyc_sram),
        .rsp_team_i(rsp_team), .rsp_la_i(rsp_la),
        .rsp_gpio_i(rsp_gpio), .rsp_sram_i(rsp_sram), .rsp_o(rsp)
    );

    team_sample u_team (
        .wb_clk_i, .rst_i, .req_i(req), .cyc_i(cyc_team), .rsp_o(rsp_team),
        .gpio_i(io_i), .gpio_o(team_gpio), .gpio_oeb_o(team_oeb), .la_o(team_la)
    );

    la_control u_la (
        .wb_clk_i, .rst_i, .req_i(req), .cyc_i(cyc_la), .rsp_o(rsp_la),
        .team_la_i(team_la), .la_data_o
    );

    gpio_control u_gpio (
        .wb_clk_i, .rst_i, .req_i(req), .cyc_i(cyc_gpio), .rsp_o(rsp_gpio),
        .team_gpio_i(team_gpio), .team_oeb_i(team_oeb), .io_o, .io_oeb_o
    );

    wb_sram u_sram (
        .wb_clk_i, .rst_i, .req_i(req), .cyc_i(cyc_sram), .rsp_o(rsp_sram)
    );

endmodule

// File: rtl/team_sample.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample team design: OUT/OEB registers drive the
// pins and analyzer, IN reads the low pins back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module team_sample (
    input  logic                           wb_clk_i,
    input  logic                           rst_i,
    input  nebula_pkg::wb_req_t            req_i,
    input  logic                           cyc_i,
    output nebula_pkg::wb_rsp_t            rsp_o,
    input  logic [nebula_pkg::GPIO_W-1:0]  gpio_i,
    output logic [nebula_pkg::GPIO_W-1:0]  gpio_o,
    output logic [nebula_pkg::GPIO_W-1:0]  gpio_oeb_o,
    output logic [nebula_pkg::LA_W-1:0]    la_o
);

    logic [31:0] out_q;
    logic [31:0] oeb_q;
    logic [1:0]  ofs;   // Register word select
    logic        wr_en;

    assign ofs   = req_i.adr[3:2];
    assign wr_en = cyc_i && rsp_o.ack && req_i.we;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            rsp_o.ack <= 1'b0;
            out_q     <= '0;
            oeb_q     <= '0;
        end else begin
            rsp_o.ack <= cyc_i && !rsp_o.ack;
            if (wr_en && ofs == nebula_pkg::TEAM_OUT_OFS)
                out_q <= nebula_pkg::wb_merge(out_q, req_i.dat, req_i.sel);
            if (wr_en && ofs == nebula_pkg::TEAM_OEB_OFS)
                oeb_q <= nebula_pkg::wb_merge(oeb_q, req_i.dat, req_i.sel);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (cyc_i && !rsp_o.ack) begin
            case (ofs)
                nebula_pkg::TEAM_OUT_OFS: rsp_o.dat <= out_q;
                nebula_pkg::TEAM_OEB_OFS: rsp_o.dat <= oeb_q;
                nebula_pkg::TEAM_IN_OFS:  rsp_o.dat <= gpio_i[31:0];  // Live pins
                default:                  rsp_o.dat <= 32'b0;
            endcase
        end
    end

    assign gpio_o     = {6'b0, out_q};
    assign gpio_oeb_o = {6'h3f, oeb_q};    // Top pins never enabled
    assign la_o       = {96'b0, out_q};

endmodule

// File: rtl/wb_sram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Small word SRAM on the bus; byte-lane writes,
// registered reads, upper slot bits alias
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_sram (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    input  nebula_pkg::wb_req_t req_i,
    input  logic                cyc_i,
    output nebula_pkg::wb_rsp_t rsp_o
);

    logic [31:0]                    mem [nebula_pkg::SRAM_WORDS];
    logic [nebula_pkg::SRAM_AW-1:0] idx;   // Word address
    logic                           wr_en;

    assign idx   = req_i.adr[nebula_pkg::SRAM_AW+1:2];
    assign wr_en = cyc_i && rsp_o.ack && req_i.we;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i)
            rsp_o.ack <= 1'b0;
        else
            rsp_o.ack <= cyc_i && !rsp_o.ack;
    end

    // Array write, one byte lane at a time
    always_ff @(posedge wb_clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.sel[b])
                    mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
        end
    end

    // Read port, sampled in the cycle before ack
    always_ff @(posedge wb_clk_i) begin
        if (cyc_i && !rsp_o.ack)
            rsp_o.dat <= mem[idx];
    end

endmodule

// File: rtl/la_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Logic-analyzer routing: one select bit per 32-bit
// analyzer word, team word or zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module la_control (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  nebula_pkg::wb_req_t             req_i,
    input  logic                            cyc_i,
    output nebula_pkg::wb_rsp_t             rsp_o,
    input  logic [nebula_pkg::LA_W-1:0]     team_la_i,
    output logic [nebula_pkg::LA_W-1:0]     la_data_o
);

    localparam int NWORDS = nebula_pkg::LA_W / 32;

    logic [NWORDS-1:0] sel_q;     // Bit n gates word n
    logic [31:0]       sel_next;

    assign sel_next = nebula_pkg::wb_merge({28'b0, sel_q}, req_i.dat, req_i.sel);

    // Single register, offsets alias
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            rsp_o.ack <= 1'b0;
            sel_q     <= '0;
        end else begin
            rsp_o.ack <= cyc_i && !rsp_o.ack;
            if (cyc_i && rsp_o.ack && req_i.we)
                sel_q <= sel_next[NWORDS-1:0];  // Lands as ack ends
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (cyc_i && !rsp_o.ack)
            rsp_o.dat <= {28'b0, sel_q};
    end

    always_comb begin
        for (int w = 0; w < NWORDS; w++)
            la_data_o[32*w +: 32] = sel_q[w] ? team_la_i[32*w +: 32] : 32'b0;
    end

endmodule

// File: rtl/gpio_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO routing: per-pin select between team outputs
// and the safe default (zero, output disabled)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module gpio_control (
    input  logic                              wb_clk_i,
    input  logic                              rst_i,
    input  nebula_pkg::wb_req_t               req_i,
    input  logic                              cyc_i,
    output nebula_pkg::wb_rsp_t               rsp_o,
    input  logic [nebula_pkg::GPIO_W-1:0]     team_gpio_i,
    input  logic [nebula_pkg::GPIO_W-1:0]     team_oeb_i,  // Active low
    output logic [nebula_pkg::GPIO_W-1:0]     io_o,
    output logic [nebula_pkg::GPIO_W-1:0]     io_oeb_o
);

    logic [31:0]                    sel_lo_q;   // Pins 31:0
    logic [nebula_pkg::GPIO_W-33:0] sel_hi_q;   // Pins 37:32
    logic [nebula_pkg::GPIO_W-1:0]  sel_all;
    logic [31:0]                    lo_next;
    logic [31:0]                    hi_next;
    logic                           hi_ofs;     // Word 1 is SEL_HI
    logic                           wr_en;

    assign hi_ofs  = req_i.adr[2];
    assign wr_en   = cyc_i && rsp_o.ack && req_i.we;  // Commit on ack edge
    assign lo_next = nebula_pkg::wb_merge(sel_lo_q, req_i.dat, req_i.sel);
    assign hi_next = nebula_pkg::wb_merge({26'b0, sel_hi_q}, req_i.dat, req_i.sel);

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            rsp_o.ack <= 1'b0;
            sel_lo_q  <= '0;
            sel_hi_q  <= '0;
        end else begin
            rsp_o.ack <= cyc_i && !rsp_o.ack; // Single ack per request
            if (wr_en && !hi_ofs)
                sel_lo_q <= lo_next;
            if (wr_en && hi_ofs)
                sel_hi_q <= hi_next[nebula_pkg::GPIO_W-33:0];
        end
    end

    // Read data, registered with ack
    always_ff @(posedge wb_clk_i) begin
        if (cyc_i && !rsp_o.ack)
            rsp_o.dat <= hi_ofs ? {26'b0, sel_hi_q} : sel_lo_q;
    end

    assign sel_all  = {sel_hi_q, sel_lo_q};
    assign io_o     = team_gpio_i & sel_all;   // Unselected pins drive zero
    assign io_oeb_o = team_oeb_i | ~sel_all;   // and stay disabled

endmodule

// File: rtl/wb_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot decoder: steers cyc to one slave, merges the
// responses and acks unmapped addresses itself
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_decoder (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    input  nebula_pkg::wb_req_t req_i,
    input  logic                req_valid_i,
    output logic                cyc_team_o,
    output logic                cyc_la_o,
    output logic                cyc_gpio_o,
    output logic                cyc_sram_o,
    input  nebula_pkg::wb_rsp_t rsp_team_i,
    input  nebula_pkg::wb_rsp_t rsp_la_i,
    input  nebula_pkg::wb_rsp_t rsp_gpio_i,
    input  nebula_pkg::wb_rsp_t rsp_sram_i,
    output nebula_pkg::wb_rsp_t rsp_o
);

    logic [3:0] slot;
    logic       base_hit;
    logic       mapped;
    logic       err_ack_q;  // Error responder ack

    assign slot     = req_i.adr[23:20];
    assign base_hit = (req_i.adr[31:24] == nebula_pkg::WB_BASE[31:24]);
    assign mapped   = base_hit && (slot <= nebula_pkg::SLOT_SRAM);

    // At most one cyc high
    assign cyc_team_o = req_valid_i && mapped && (slot == nebula_pkg::SLOT_TEAM);
    assign cyc_la_o   = req_valid_i && mapped && (slot == nebula_pkg::SLOT_LA);
    assign cyc_gpio_o = req_valid_i && mapped && (slot == nebula_pkg::SLOT_GPIO);
    assign cyc_sram_o = req_valid_i && mapped && (slot == nebula_pkg::SLOT_SRAM);

    // Same latency as a real slave, so the bus never hangs
    always_ff @(posedge wb_clk_i) begin
        if (rst_i)
            err_ack_q <= 1'b0;
        else
            err_ack_q <= req_valid_i && !mapped && !err_ack_q;
    end

    // Response mux on the held slot
    always_comb begin
        rsp_o = '0;
        if (!mapped) begin
            rsp_o.ack = err_ack_q;
            rsp_o.dat = nebula_pkg::ERR_DATA;
        end else begin
            case (slot)
                nebula_pkg::SLOT_TEAM: rsp_o = rsp_team_i;
                nebula_pkg::SLOT_LA:   rsp_o = rsp_la_i;
                nebula_pkg::SLOT_GPIO: rsp_o = rsp_gpio_i;
                default:               rsp_o = rsp_sram_i; // Only SRAM left
            endcase
        end
    end

endmodule

// File: rtl/wb_request_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host-side stage: captures one Wishbone request and
// returns the slave response to the host
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_request_stage (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    // Host side, Wishbone classic
    input  logic                wbs_stb_i,
    input  logic                wbs_cyc_i,
    input  logic                wbs_we_i,
    input  logic [3:0]          wbs_sel_i,
    input  logic [31:0]         wbs_dat_i,
    input  logic [31:0]         wbs_adr_i,
    output logic                wbs_ack_o,
    output logic [31:0]         wbs_dat_o,
    // Toward the decoder
    output nebula_pkg::wb_req_t req_o,
    output logic                req_valid_o,
    input  nebula_pkg::wb_rsp_t rsp_i
);

    logic start; // New transaction seen while idle

    assign start = wbs_cyc_i && wbs_stb_i && !req_valid_o;

    // Payload, held until ack
    always_ff @(posedge wb_clk_i) begin
        if (start) begin
            req_o.adr <= wbs_adr_i;
            req_o.dat <= wbs_dat_i;
            req_o.sel <= wbs_sel_i;
            req_o.we  <= wbs_we_i;
        end
    end

    // One item in flight
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            req_valid_o <= 1'b0;
        end else if (start) begin
            req_valid_o <= 1'b1;
        end else if (rsp_i.ack) begin
            req_valid_o <= 1'b0;   // Released on the ack edge
        end
    end

    assign wbs_ack_o = rsp_i.ack;  // Straight from the slave, one cycle
    assign wbs_dat_o = rsp_i.dat;

endmodule

// File: rtl/nebula_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared Wishbone structs, address map and sizes for the
// user-area shell; referenced by scoped names only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package nebula_pkg;

    // Request as held by the first stage
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;   // Byte lanes
        logic        we;
    } wb_req_t;

    // Slave response back toward the host
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    localparam logic [31:0] WB_BASE = 32'h3000_0000; // Upper byte must match

    // Slot numbers, address bits 23:20
    localparam logic [3:0] SLOT_TEAM = 4'd0;
    localparam logic [3:0] SLOT_LA   = 4'd1;
    localparam logic [3:0] SLOT_GPIO = 4'd2;
    localparam logic [3:0] SLOT_SRAM = 4'd3;

    // Register word offsets, address bits 3:2
    localparam logic [1:0] TEAM_OUT_OFS = 2'd0;
    localparam logic [1:0] TEAM_OEB_OFS = 2'd1;
    localparam logic [1:0] TEAM_IN_OFS  = 2'd2;

    localparam int SRAM_WORDS = 256;
    localparam int SRAM_AW    = 8;
    localparam int GPIO_W     = 38;
    localparam int LA_W       = 128;

    localparam logic [31:0] ERR_DATA = 32'hBADD_1E00; // Unmapped read pattern

    // Byte-lane merge of write data into an old word
    function automatic logic [31:0] wb_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  sel);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (sel[b])
                res[8*b +: 8] = new_val[8*b +: 8];
        end
        return res;
    endfunction

endpackage
